// ==== design/clockPkg.sv ====
package clockPkg;

    ////////////////////////////////////////////////////////////
    // time of day
    ////////////////////////////////////////////////////////////

    // six bcd digits, msb field first so secOnes lands in [3:0]
    typedef struct packed {
        logic [3:0] hrTens;
        logic [3:0] hrOnes;
        logic [3:0] minTens;
        logic [3:0] minOnes;
        logic [3:0] secTens;
        logic [3:0] secOnes;
    } bcdTime_t;

    // same 24 bits seen as fields or as a digit array
    typedef union packed {
        bcdTime_t        field;   // counter works on names
        logic [5:0][3:0] digit;   // digit[0] = secOnes .. digit[5] = hrTens
    } timeWord_t;

    localparam int digitCount = 6;

    typedef logic [2:0] cursor_t;   // 0 = secOnes, 5 = hrTens

    typedef enum logic [1:0] {
        modeRun      = 2'd0,
        modeSetTime  = 2'd1,
        modeSetAlarm = 2'd2     // 3 falls back to run behaviour
    } mode_t;

    // per-digit upper limits
    localparam logic [3:0] maxOnes      = 4'd9;
    localparam logic [3:0] maxSecTens   = 4'd5;
    localparam logic [3:0] maxMinTens   = 4'd5;
    localparam logic [3:0] maxHrTens    = 4'd2;
    localparam logic [3:0] maxHrOnesAt2 = 4'd3;   // 20..23 only

    ////////////////////////////////////////////////////////////
    // seven segment, active low {a,b,c,d,e,f,g}
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] segDigit [0:9] = '{
        7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110, 7'b1001100,
        7'b0100100, 7'b0100000, 7'b0001111, 7'b0000000, 7'b0000100
    };
    localparam logic [6:0] segBlank      = 7'b1111111;
    localparam logic [6:0] segGlyphSet   = 7'b0100100;   // S, same as a 5
    localparam logic [6:0] segGlyphAlarm = 7'b0001000;   // A

    // board defaults, 100 MHz clk
    localparam logic [31:0] defTicksPerSecond = 32'd100_000_000;
    localparam logic [31:0] defScanPeriod     = 32'd1024;
    localparam logic [31:0] defBlinkHalf      = 32'd50_000_000;   // 1 Hz blink
    localparam logic [31:0] defToneHalf       = 32'd67_568;       // ~740 Hz tone

endpackage

// ==== design/tickGen.sv ====
`timescale 1ns/100ps

module tickGen #(
    parameter logic [31:0] ticksPerSecond = clockPkg::defTicksPerSecond,
    parameter logic [31:0] scanPeriod     = clockPkg::defScanPeriod,
    parameter logic [31:0] blinkHalf      = clockPkg::defBlinkHalf,
    parameter logic [31:0] toneHalf       = clockPkg::defToneHalf
) (
    input  logic clk,
    input  logic arstN,
    output logic secTick,     // one clk wide, once a second
    output logic scanTick,    // one clk wide, once per scan slot
    output logic blinkPhase,  // square wave for cursor blink
    output logic toneSq       // square wave for the speaker
);

    // 0 = second, 1 = scan, 2 = blink, 3 = tone
    localparam logic [3:0][31:0] periods = {toneHalf, blinkHalf, scanPeriod, ticksPerSecond};

    logic [3:0][31:0] cnt;
    logic [3:0]       outBit;   // [1:0] pulses, [3:2] toggles

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            cnt    <= '0;
            outBit <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (cnt[i] == periods[i] - 32'd1)
                begin
                    cnt[i]    <= '0;
                    outBit[i] <= (i < 2) ? 1'b1 : ~outBit[i];   // pulse or toggle
                end
                else
                begin
                    cnt[i] <= cnt[i] + 32'd1;
                    if (i < 2)
                        outBit[i] <= 1'b0;   // pulses drop after one clk
                end
            end
        end
    end

    assign secTick    = outBit[0];
    assign scanTick   = outBit[1];
    assign blinkPhase = outBit[2];
    assign toneSq     = outBit[3];

endmodule

// ==== design/buttonSync.sv ====
`timescale 1ns/100ps

module buttonSync (
    input  logic                clk,
    input  logic                arstN,
    input  logic                up,
    input  logic                down,
    input  logic                left,
    input  logic                right,
    input  logic                middle,
    input  logic [1:0]          switch,
    output logic                upPulse,
    output logic                downPulse,
    output logic                leftPulse,
    output logic                rightPulse,
    output logic                middlePulse,
    output clockPkg::mode_t     mode
);

    logic [4:0] btnMeta;    // first flop, may go metastable
    logic [4:0] btnSync;    // second flop, safe to use
    logic [4:0] btnLast;    // third flop, edge history
    logic [4:0] btnPulse;   // registered rising edges
    logic [1:0] swMeta;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            btnMeta  <= '0;
            btnSync  <= '0;
            btnLast  <= '0;
            btnPulse <= '0;
            swMeta   <= '0;
            mode     <= clockPkg::modeRun;
        end
        else
        begin
            btnMeta  <= {middle, right, left, down, up};
            btnSync  <= btnMeta;
            btnLast  <= btnSync;
            btnPulse <= btnSync & ~btnLast;   // one pulse per press, held or not
            swMeta   <= switch;
            mode     <= clockPkg::mode_t'(swMeta);   // 3 passes through, acts as run
        end
    end

    assign upPulse     = btnPulse[0];
    assign downPulse   = btnPulse[1];
    assign leftPulse   = btnPulse[2];
    assign rightPulse  = btnPulse[3];
    assign middlePulse = btnPulse[4];

endmodule

// ==== design/timeKeeper.sv ====
`timescale 1ns/100ps

module timeKeeper (
    input  logic                clk,
    input  logic                arstN,
    input  logic                secTick,
    input  clockPkg::mode_t     mode,
    input  logic                loadTime,
    input  clockPkg::timeWord_t editWord,
    output clockPkg::timeWord_t nowTime
);

    clockPkg::bcdTime_t cur;
    clockPkg::bcdTime_t nxt;   // current time plus one second
    logic c1, c2, c3, c4;      // carries out of each lower digit

    assign cur = nowTime.field;

    ////////////////////////////////////////////////////////////
    // chained bcd increment
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        nxt = cur;
        c1  = (cur.secOnes == clockPkg::maxOnes);
        c2  = c1 && (cur.secTens == clockPkg::maxSecTens);
        c3  = c2 && (cur.minOnes == clockPkg::maxOnes);
        c4  = c3 && (cur.minTens == clockPkg::maxMinTens);

        nxt.secOnes = c1 ? 4'd0 : cur.secOnes + 4'd1;
        if (c1)
            nxt.secTens = c2 ? 4'd0 : cur.secTens + 4'd1;
        if (c2)
            nxt.minOnes = c3 ? 4'd0 : cur.minOnes + 4'd1;
        if (c3)
            nxt.minTens = c4 ? 4'd0 : cur.minTens + 4'd1;

        // hours, 23 -> 00 ends the day
        if (c4 && cur.hrTens == clockPkg::maxHrTens && cur.hrOnes == clockPkg::maxHrOnesAt2)
        begin
            nxt.hrTens = 4'd0;
            nxt.hrOnes = 4'd0;
        end
        else if (c4 && cur.hrOnes == clockPkg::maxOnes)
        begin
            nxt.hrOnes = 4'd0;
            nxt.hrTens = cur.hrTens + 4'd1;
        end
        else if (c4)
            nxt.hrOnes = cur.hrOnes + 4'd1;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            nowTime <= '0;
        else if (loadTime)
            nowTime <= editWord;   // edit beats the tick
        else if (secTick && mode != clockPkg::modeSetTime)
            nowTime.field <= nxt;  // frozen while setting
    end

    // counter and editor together must keep a legal time
    assert property (@(posedge clk) disable iff (!arstN)
        cur.secOnes <= clockPkg::maxOnes && cur.secTens <= clockPkg::maxSecTens &&
        cur.minOnes <= clockPkg::maxOnes && cur.minTens <= clockPkg::maxMinTens &&
        cur.hrOnes <= clockPkg::maxOnes && cur.hrTens <= clockPkg::maxHrTens &&
        !(cur.hrTens == clockPkg::maxHrTens && cur.hrOnes > clockPkg::maxHrOnesAt2));

endmodule

// ==== design/timeEditor.sv ====
`timescale 1ns/100ps

module timeEditor (
    input  logic                clk,
    input  logic                arstN,
    input  clockPkg::mode_t     mode,
    input  logic                upPulse,
    input  logic                downPulse,
    input  logic                leftPulse,
    input  logic                rightPulse,
    input  clockPkg::timeWord_t nowTime,
    input  clockPkg::timeWord_t alarmTime,
    output clockPkg::cursor_t   cursor,
    output clockPkg::timeWord_t editWord,
    output logic                loadTime,
    output logic                loadAlarm
);

    logic                setMode;
    clockPkg::timeWord_t srcWord;    // word under edit
    clockPkg::timeWord_t editNext;   // srcWord with one digit changed
    logic [3:0]          curDigit;
    logic [3:0]          limit;      // highest legal value at cursor
    logic [3:0]          newDigit;

    assign setMode = (mode == clockPkg::modeSetTime) || (mode == clockPkg::modeSetAlarm);

    always_comb
    begin
        srcWord  = (mode == clockPkg::modeSetAlarm) ? alarmTime : nowTime;
        curDigit = srcWord.digit[cursor];
        case (cursor)
            3'd1:    limit = clockPkg::maxSecTens;
            3'd3:    limit = clockPkg::maxMinTens;
            3'd4:    limit = (srcWord.field.hrTens == clockPkg::maxHrTens) ?
                             clockPkg::maxHrOnesAt2 : clockPkg::maxOnes;
            3'd5:    limit = clockPkg::maxHrTens;
            default: limit = clockPkg::maxOnes;   // all ones digits
        endcase

        if (upPulse)
            newDigit = (curDigit >= limit) ? 4'd0 : curDigit + 4'd1;
        else
            newDigit = (curDigit == 4'd0) ? limit : curDigit - 4'd1;

        editNext = srcWord;
        editNext.digit[cursor] = newDigit;
        // tens going to 2 can leave 24..29 behind
        if (editNext.field.hrTens == clockPkg::maxHrTens &&
            editNext.field.hrOnes > clockPkg::maxHrOnesAt2)
            editNext.field.hrOnes = clockPkg::maxHrOnesAt2;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            cursor    <= '0;
            editWord  <= '0;
            loadTime  <= 1'b0;
            loadAlarm <= 1'b0;
        end
        else
        begin
            loadTime  <= 1'b0;
            loadAlarm <= 1'b0;
            if (setMode)   // run mode ignores every button
            begin
                if (leftPulse)   // toward hrTens
                    cursor <= (cursor == clockPkg::cursor_t'(clockPkg::digitCount - 1)) ?
                              '0 : cursor + 3'd1;
                else if (rightPulse)   // toward secOnes
                    cursor <= (cursor == '0) ?
                              clockPkg::cursor_t'(clockPkg::digitCount - 1) : cursor - 3'd1;

                if (upPulse || downPulse)
                begin
                    editWord  <= editNext;
                    loadTime  <= (mode == clockPkg::modeSetTime);
                    loadAlarm <= (mode == clockPkg::modeSetAlarm);
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        cursor <= clockPkg::cursor_t'(clockPkg::digitCount - 1));

endmodule

// ==== design/alarmUnit.sv ====
`timescale 1ns/100ps

module alarmUnit (
    input  logic                clk,
    input  logic                arstN,
    input  clockPkg::mode_t     mode,
    input  logic                loadAlarm,
    input  clockPkg::timeWord_t editWord,
    input  clockPkg::timeWord_t nowTime,
    input  logic                middlePulse,
    input  logic                toneSq,
    output clockPkg::timeWord_t alarmTime,
    output logic                speaker
);

    logic armed;     // set by any alarm edit
    logic ringing;   // latched match, held until middle
    logic runMode;
    logic match;

    // mode 3 counts as run
    assign runMode = (mode != clockPkg::modeSetTime) && (mode != clockPkg::modeSetAlarm);
    assign match   = armed && runMode && (nowTime == alarmTime);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            alarmTime <= '0;
            armed     <= 1'b0;
            ringing   <= 1'b0;
            speaker   <= 1'b0;
        end
        else
        begin
            if (loadAlarm)
            begin
                alarmTime <= editWord;
                armed     <= 1'b1;
            end
            if (match)
                ringing <= 1'b1;   // stays on after the second moves on
            if (middlePulse)       // silence wins over a same-cycle match
            begin
                ringing <= 1'b0;
                armed   <= 1'b0;
            end
            speaker <= toneSq & ringing;
        end
    end

endmodule

// ==== design/displayScan.sv ====
`timescale 1ns/100ps

module displayScan (
    input  logic                clk,
    input  logic                arstN,
    input  logic                scanTick,
    input  clockPkg::mode_t     mode,
    input  clockPkg::timeWord_t nowTime,
    input  clockPkg::timeWord_t alarmTime,
    input  clockPkg::cursor_t   cursor,
    input  logic                blinkPhase,
    output logic [7:0]          anode,   // active low
    output logic [6:0]          seg      // active low {a..g}
);

    logic [2:0]          pos;        // 0..5 digits, 6 glyph
    logic                setMode;
    clockPkg::timeWord_t srcWord;
    logic [3:0]          curDigit;
    logic [7:0]          anodeNext;
    logic [6:0]          segNext;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pos <= '0;
        else if (scanTick)
            pos <= (pos == 3'(clockPkg::digitCount)) ? 3'd0 : pos + 3'd1;
    end

    ////////////////////////////////////////////////////////////
    // slot decode
    ////////////////////////////////////////////////////////////

    assign setMode = (mode == clockPkg::modeSetTime) || (mode == clockPkg::modeSetAlarm);
    assign srcWord = (mode == clockPkg::modeSetAlarm) ? alarmTime : nowTime;

    always_comb
    begin
        anodeNext = '1;
        segNext   = clockPkg::segBlank;
        curDigit  = '0;
        if (pos == 3'(clockPkg::digitCount))
        begin
            anodeNext[7] = 1'b0;   // glyph sits on the last anode, 6 stays dark
            case (mode)
                clockPkg::modeSetTime:  segNext = clockPkg::segGlyphSet;
                clockPkg::modeSetAlarm: segNext = clockPkg::segGlyphAlarm;
                default:                segNext = clockPkg::segBlank;
            endcase
        end
        else
        begin
            curDigit = srcWord.digit[pos];
            segNext  = (curDigit > clockPkg::maxOnes) ? clockPkg::segBlank :
                       clockPkg::segDigit[curDigit];
            // cursor digit goes dark on the high half of blink
            if (!(setMode && blinkPhase && pos == cursor))
                anodeNext[pos] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            anode <= '1;   // all off
            seg   <= clockPkg::segBlank;
        end
        else
        begin
            anode <= anodeNext;
            seg   <= segNext;
        end
    end

    // never two digits driven at once
    assert property (@(posedge clk) disable iff (!arstN) $onehot0(~anode));

endmodule

// ==== design/clockTop.sv ====
`timescale 1ns/100ps

module clockTop #(
    parameter logic [31:0] ticksPerSecond = clockPkg::defTicksPerSecond,
    parameter logic [31:0] scanPeriod     = clockPkg::defScanPeriod,
    parameter logic [31:0] blinkHalf      = clockPkg::defBlinkHalf,
    parameter logic [31:0] toneHalf       = clockPkg::defToneHalf
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       up,       // digit up in set modes
    input  logic       down,     // digit down in set modes
    input  logic       left,     // cursor toward hours
    input  logic       right,    // cursor toward seconds
    input  logic       middle,   // silence and disarm
    input  logic [1:0] switch,   // mode select
    output logic [7:0] anode,
    output logic [6:0] seg,
    output logic       speaker
);

    logic secTick, scanTick, blinkPhase, toneSq;
    logic upPulse, downPulse, leftPulse, rightPulse, middlePulse;
    logic loadTime, loadAlarm;

    clockPkg::mode_t     mode;
    clockPkg::cursor_t   cursor;
    clockPkg::timeWord_t nowTime;
    clockPkg::timeWord_t alarmTime;
    clockPkg::timeWord_t editWord;   // shared by time and alarm loads

    tickGen #(
        .ticksPerSecond(ticksPerSecond),
        .scanPeriod    (scanPeriod),
        .blinkHalf     (blinkHalf),
        .toneHalf      (toneHalf)
    ) u_tickGen (
        .clk(clk), .arstN(arstN), .secTick(secTick), .scanTick(scanTick),
        .blinkPhase(blinkPhase), .toneSq(toneSq)
    );

    buttonSync u_buttonSync (
        .clk(clk), .arstN(arstN), .up(up), .down(down), .left(left), .right(right),
        .middle(middle), .switch(switch), .upPulse(upPulse), .downPulse(downPulse),
        .leftPulse(leftPulse), .rightPulse(rightPulse), .middlePulse(middlePulse),
        .mode(mode)
    );

    timeKeeper u_timeKeeper (
        .clk(clk), .arstN(arstN), .secTick(secTick), .mode(mode),
        .loadTime(loadTime), .editWord(editWord), .nowTime(nowTime)
    );

    timeEditor u_timeEditor (
        .clk(clk), .arstN(arstN), .mode(mode), .upPulse(upPulse), .downPulse(downPulse),
        .leftPulse(leftPulse), .rightPulse(rightPulse), .nowTime(nowTime),
        .alarmTime(alarmTime), .cursor(cursor), .editWord(editWord),
        .loadTime(loadTime), .loadAlarm(loadAlarm)
    );

    alarmUnit u_alarmUnit (
        .clk(clk), .arstN(arstN), .mode(mode), .loadAlarm(loadAlarm),
        .editWord(editWord), .nowTime(nowTime), .middlePulse(middlePulse),
        .toneSq(toneSq), .alarmTime(alarmTime), .speaker(speaker)
    );

    displayScan u_displayScan (
        .clk(clk), .arstN(arstN), .scanTick(scanTick), .mode(mode), .nowTime(nowTime),
        .alarmTime(alarmTime), .cursor(cursor), .blinkPhase(blinkPhase),
        .anode(anode), .seg(seg)
    );

endmodule

// ==== test/tbClock.sv ====
`timescale 1ns/100ps

module tbClock;

    localparam int ticksPerSecond = 400;
    localparam int scanPeriod     = 4;
    localparam int blinkHalf      = 100;
    localparam int toneHalf       = 3;
    localparam int scanWindow     = 7 * scanPeriod * 2;   // two full scans
    // about ten clock seconds plus edits is near 9k cycles, twice that as margin
    localparam int maxCycles      = 20000;

    localparam logic [7:0] digitMask  = 8'hBF;   // anodes 0..5 and the glyph on 7
    localparam logic [6:0] glyphBlank = 7'b1111111;
    localparam logic [6:0] glyphS     = 7'b0100100;
    localparam logic [6:0] glyphA     = 7'b0001000;

    localparam int btnUp     = 0;
    localparam int btnDown   = 1;
    localparam int btnLeft   = 2;
    localparam int btnRight  = 3;
    localparam int btnMiddle = 4;

    logic       clk = 1'b0;
    logic       arstN;
    logic [4:0] btns;        // {middle, right, left, down, up}
    logic [1:0] switch;
    logic [7:0] anode;
    logic [6:0] seg;
    logic       speaker;

    int cycleCount = 0;
    int checkCount = 0;
    int errCount   = 0;

    logic [3:0]  shown [0:5];        // last digit decoded per anode
    logic [6:0]  glyph;              // last pattern on anode 7
    logic [7:0]  litSeen;            // per window
    logic [7:0]  darkSeen;           // slot came round with nothing lit
    int          lastLit   = -1;
    logic        anode6Lit = 1'b0;
    logic        spkHigh;
    logic        spkLow;
    logic        tickNow;
    logic [23:0] expTime   = '0;     // bcd, secOnes in [3:0]
    logic [23:0] expAlarm  = '0;
    int          expCursor = 0;

    clockTop #(
        .ticksPerSecond(ticksPerSecond),
        .scanPeriod    (scanPeriod),
        .blinkHalf     (blinkHalf),
        .toneHalf      (toneHalf)
    ) u_dut (
        .clk(clk), .arstN(arstN), .up(btns[0]), .down(btns[1]), .left(btns[2]),
        .right(btns[3]), .middle(btns[4]), .switch(switch), .anode(anode), .seg(seg),
        .speaker(speaker)
    );

    always #4 clk = ~clk;   // 8 ns period

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= maxCycles)
        begin
            $display("run stopped after %0d cycles, the tests did not finish", cycleCount);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////

    function automatic logic [3:0] segToDigit(input logic [6:0] s);
        case (s)   // active low {a..g}
            7'b0000001: segToDigit = 4'd0;
            7'b1001111: segToDigit = 4'd1;
            7'b0010010: segToDigit = 4'd2;
            7'b0000110: segToDigit = 4'd3;
            7'b1001100: segToDigit = 4'd4;
            7'b0100100: segToDigit = 4'd5;
            7'b0100000: segToDigit = 4'd6;
            7'b0001111: segToDigit = 4'd7;
            7'b0000000: segToDigit = 4'd8;
            7'b0000100: segToDigit = 4'd9;
            default:    segToDigit = 4'hF;   // blank or garbage
        endcase
    endfunction

    // scan order is anodes 0..5 then 7
    function automatic int nextScanAnode(input int a);
        if (a == 5)
            return 7;
        else if (a == 7)
            return 0;
        else
            return a + 1;
    endfunction

    function automatic logic [23:0] editModel(input logic [23:0] w, input int pos,
                                              input logic isUp);
        logic [23:0] r;
        logic [3:0]  d;
        logic [3:0]  lim;
        r = w;
        d = w[4*pos +: 4];
        case (pos)
            1, 3:    lim = 4'd5;                              // tens of sec and min
            4:       lim = (w[23:20] == 4'd2) ? 4'd3 : 4'd9;  // 20..23 only
            5:       lim = 4'd2;
            default: lim = 4'd9;
        endcase
        if (isUp)
            d = (d >= lim) ? 4'd0 : d + 4'd1;
        else
            d = (d == 4'd0) ? lim : d - 4'd1;
        r[4*pos +: 4] = d;
        if (r[23:20] == 4'd2 && r[19:16] > 4'd3)
            r[19:16] = 4'd3;
        return r;
    endfunction

    // one second on, done in plain seconds of the day
    function automatic logic [23:0] tickModel(input logic [23:0] w);
        int secs;
        secs = 36000 * int'(w[23:20]) + 3600 * int'(w[19:16]) + 600 * int'(w[15:12]) +
               60 * int'(w[11:8]) + 10 * int'(w[7:4]) + int'(w[3:0]);
        secs = (secs + 1) % 86400;
        return {4'(secs / 36000), 4'((secs / 3600) % 10), 4'((secs % 3600) / 600),
                4'((secs / 60) % 10), 4'((secs % 60) / 10), 4'(secs % 10)};
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and observation
    ////////////////////////////////////////////////////////////

    // one falling edge, outputs settled since the rising edge
    task automatic sample();
        int litIdx;
        @(negedge clk);
        litIdx = -1;
        for (int i = 0; i < 8; i++)
            if (!anode[i])
                litIdx = i;
        if (litIdx >= 0)
        begin
            litSeen[litIdx] = 1'b1;
            if (litIdx == 6)
                anode6Lit = 1'b1;
            else if (litIdx == 7)
                glyph = seg;
            else
                shown[litIdx] = segToDigit(seg);
            lastLit = litIdx;
        end
        else if (lastLit >= 0)
            darkSeen[nextScanAnode(lastLit)] = 1'b1;   // blanked slot
        if (speaker)
            spkHigh = 1'b1;
        else
            spkLow = 1'b1;
        tickNow = u_dut.u_tickGen.secTick;   // only used to line up readings
    endtask

    task automatic readDisplay();
        litSeen  = '0;
        darkSeen = '0;
        repeat (scanWindow) sample();
    endtask

    // windows until every digit and the glyph have shown, blink may hide one
    task automatic readTime();
        logic [7:0] litAll;
        int         tries;
        litAll = '0;
        tries  = 0;
        while ((litAll & digitMask) != digitMask && tries < 5)
        begin
            readDisplay();
            litAll = litAll | litSeen;
            tries++;
        end
        if ((litAll & digitMask) != digitMask)
        begin
            errCount++;
            $display("display did not light every digit within %0d scans", 2 * tries);
        end
    endtask

    task automatic clearSpeaker();
        spkHigh = 1'b0;
        spkLow  = 1'b0;
    endtask

    task automatic press(input int which);
        sample();
        btns[which] = 1'b1;
        repeat (6) sample();
        btns[which] = 1'b0;
        repeat (6) sample();
    endtask

    // returns one edge after the drive, the mode flips on the next rising edge
    task automatic setMode(input logic [1:0] m);
        sample();
        switch = m;
        sample();
    endtask

    task automatic waitSecond();
        int n;
        n = 0;
        do
        begin
            sample();
            n++;
        end
        while (!tickNow && n < ticksPerSecond + 8);
        if (!tickNow)
        begin
            errCount++;
            $display("no second tick came within %0d cycles", n);
        end
        repeat (2) sample();   // counter, then display register
    endtask

    task automatic editDigit(input logic isUp, input logic toAlarm);
        press(isUp ? btnUp : btnDown);
        if (toAlarm)
            expAlarm = editModel(expAlarm, expCursor, isUp);
        else
            expTime = editModel(expTime, expCursor, isUp);
    endtask

    task automatic moveCursor(input logic toHours);
        press(toHours ? btnLeft : btnRight);
        if (toHours)
            expCursor = (expCursor == 5) ? 0 : expCursor + 1;
        else
            expCursor = (expCursor == 0) ? 5 : expCursor - 1;
    endtask

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errCount++;
            $display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic compareShown(input string what, input logic [23:0] expected);
        checkCount++;
        for (int i = 0; i < 6; i++)
            if (shown[i] !== expected[4*i +: 4])
            begin
                errCount++;
                $display("CHECK FAILED %s digit %0d: expected %h, got %h",
                         what, i, expected[4*i +: 4], shown[i]);
            end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic resetState();
        clearSpeaker();
        readTime();
        compareShown("time", 24'h000000);
        compareValue("glyph seg", 32'(glyphBlank), 32'(glyph));
        checkCount++;
        if (anode6Lit)
        begin
            errCount++;
            $display("anode 6 was lit after reset");
        end
        if (spkHigh)
        begin
            errCount++;
            $display("speaker went high after reset");
        end
    endtask

    task automatic editingRules();
        setMode(2'd1);
        readTime();
        compareValue("glyph seg", 32'(glyphS), 32'(glyph));
        editDigit(1'b0, 1'b0);          // secOnes 0 down wraps to 9
        readTime();
        compareShown("time", expTime);
        repeat (5) moveCursor(1'b1);    // over to hrTens
        repeat (3)
        begin
            editDigit(1'b1, 1'b0);      // 1, 2, then round to 0
            readTime();
            compareShown("time", expTime);
        end
        editDigit(1'b1, 1'b0);          // hrTens 1
        moveCursor(1'b0);
        editDigit(1'b0, 1'b0);          // hrOnes 0 down to 9, 19 h
        moveCursor(1'b1);
        editDigit(1'b1, 1'b0);          // 29 h is no time
        readTime();
        compareShown("time", expTime);
        compareValue("hour digits", 32'h23, 32'({shown[5], shown[4]}));
        repeat (5) moveCursor(1'b0);    // back down to secOnes
        moveCursor(1'b0);               // wraps round to hrTens
        editDigit(1'b1, 1'b0);          // hrTens 2 to 0 only if it wrapped
        readTime();
        compareShown("time", expTime);
    endtask

    task automatic freezeAndBlink();
        logic [7:0] litAll;
        logic [7:0] darkAll;
        litAll  = '0;
        darkAll = '0;
        repeat (6)   // half a second apart, three seconds in all
        begin
            repeat (ticksPerSecond / 2) sample();
            readTime();
            compareShown("frozen time", expTime);
        end
        repeat (4)   // 224 cycles covers a full blink period
        begin
            readDisplay();
            litAll  = litAll | litSeen;
            darkAll = darkAll | darkSeen;
        end
        checkCount++;
        if (!litAll[expCursor] || !darkAll[expCursor])
        begin
            errCount++;
            $display("cursor digit %0d did not blink", expCursor);
        end
        if ((darkAll & digitMask & ~(8'd1 << expCursor)) != 8'd0)
        begin
            errCount++;
            $display("a digit away from the cursor went dark, mask %h", darkAll);
        end
        if (anode6Lit)
        begin
            errCount++;
            $display("anode 6 was lit while editing");
        end
    endtask

    task automatic countAndRollover();
        editDigit(1'b1, 1'b0);          // hrTens 0 to 1
        editDigit(1'b1, 1'b0);          // 23 h
        moveCursor(1'b0);
        moveCursor(1'b0);               // minTens
        editDigit(1'b0, 1'b0);
        moveCursor(1'b0);
        editDigit(1'b0, 1'b0);
        moveCursor(1'b0);               // secTens
        editDigit(1'b0, 1'b0);
        moveCursor(1'b0);
        editDigit(1'b0, 1'b0);          // secOnes 9 to 8
        readTime();
        compareShown("time", 24'h235958);
        setMode(2'd0);
        repeat (3)   // 23:59:59, midnight, 00:00:01
        begin
            waitSecond();
            expTime = tickModel(expTime);
            readTime();
            compareShown("time", expTime);
        end
    endtask

    task automatic alarmRing();
        setMode(2'd1);                  // freeze, well clear of the next tick
        readTime();
        compareShown("frozen time", expTime);
        editDigit(1'b0, 1'b0);          // back to midnight, cursor still on secOnes
        readTime();
        compareShown("time", expTime);
        waitSecond();                   // ignored tick, gives a full second of room
        setMode(2'd2);
        repeat (4) editDigit(1'b1, 1'b1);
        readTime();
        compareValue("glyph seg", 32'(glyphA), 32'(glyph));
        compareShown("alarm", expAlarm);
        setMode(2'd0);
        clearSpeaker();
        repeat (3)
        begin
            waitSecond();
            expTime = tickModel(expTime);
            readTime();
            compareShown("time", expTime);
        end
        checkCount++;
        if (spkHigh)
        begin
            errCount++;
            $display("speaker sounded before the alarm time");
        end
        waitSecond();                   // time meets the alarm
        clearSpeaker();                 // speaker follows the match from here on
        expTime = tickModel(expTime);
        readTime();
        compareShown("time", expTime);
        checkCount++;
        if (!(spkHigh && spkLow))
        begin
            errCount++;
            $display("speaker did not toggle at the alarm time");
        end
        press(btnMiddle);
        clearSpeaker();
        readDisplay();
        repeat (2)                      // disarmed, nothing may ring again
        begin
            waitSecond();
            expTime = tickModel(expTime);
        end
        readTime();
        compareShown("time", expTime);
        checkCount++;
        if (spkHigh)
        begin
            errCount++;
            $display("speaker still sounded after the middle button");
        end
    endtask

    initial
    begin
        btns   = '0;
        switch = 2'd0;
        arstN  = 1'b0;
        glyph  = '1;
        clearSpeaker();
        for (int i = 0; i < 6; i++)
            shown[i] = 4'hF;
        repeat (8) @(negedge clk);
        arstN = 1'b1;

        resetState();
        editingRules();
        freezeAndBlink();
        countAndRollover();
        alarmRing();

        $display("checks run %0d, errors %0d", checkCount, errCount);
        if (errCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== tb.f ====
design/clockPkg.sv
design/tickGen.sv
design/buttonSync.sv
design/timeKeeper.sv
design/timeEditor.sv
design/alarmUnit.sv
design/displayScan.sv
design/clockTop.sv
test/tbClock.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tbClock -Mdir obj_dir -f tb.f
./obj_dir/VtbClock | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
